// ==== Makefile ====
# Verilator flow for the fetch unit testbench

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= fetch_unit_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "All tests passed" $(LOG); then \
		echo "simulation ended early, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/fetch_mem_model.sv ====
`timescale 1ns/1ns

module fetch_mem_model (
    input  logic             clk,
    input  logic             rst_i,
    input  logic [31:0]      rnd_i,
    input  logic [3:0]       delay_mask_i,
    input  logic             ar_valid_i,
    output logic             ar_ready_o,
    input  fetch_pkg::xlen_t ar_addr_i,
    output logic             r_valid_o,
    input  logic             r_ready_i,
    output fetch_pkg::beat_t r_data_o
);

    // accepted addresses and the cycle each beat may return
    fetch_pkg::xlen_t addr_q [$];
    int               due_q [$];
    int               now_c;
    int               ar_wait;

    // every word is tagged with its own byte address
    function automatic fetch_pkg::inst_t word_at(input fetch_pkg::xlen_t addr);
        return {addr[31:2], 2'b11} ^ addr[63:32];
    endfunction

    function automatic fetch_pkg::beat_t beat_at(input fetch_pkg::xlen_t addr);
        fetch_pkg::xlen_t base;
        base = {addr[63:3], 3'b000};
        return {word_at(base + 64'd4), word_at(base)};
    endfunction

    always @(posedge clk) begin
        if (rst_i) begin
            addr_q.delete();
            due_q.delete();
            now_c      = 0;
            ar_wait    = 0;
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_data_o   <= '0;
        end else begin
            now_c = now_c + 1;
            if (r_valid_o && r_ready_i) begin
                void'(addr_q.pop_front());
                void'(due_q.pop_front());
            end
            // address taken, schedule its beat and maybe stall the next one
            if (ar_valid_i && ar_ready_o) begin
                addr_q.push_back(ar_addr_i);
                due_q.push_back(now_c + int'(rnd_i[19:16] & delay_mask_i));
                ar_wait = int'(rnd_i[23:20] & delay_mask_i);
            end else if (ar_wait > 0) begin
                ar_wait = ar_wait - 1;
            end
            ar_ready_o <= ar_wait == 0;
            // beats leave strictly in request order
            if (addr_q.size() > 0 && due_q[0] <= now_c) begin
                r_valid_o <= 1'b1;
                r_data_o  <= beat_at(addr_q[0]);
            end else begin
                r_valid_o <= 1'b0;
            end
        end
    end

endmodule

// ==== dv/fetch_unit_tb.sv ====
`timescale 1ns/1ns

module fetch_unit_tb;

    localparam fetch_pkg::xlen_t RESET_PC     = 64'h8000_0000;
    localparam int               FETCH_DEPTH  = 2;
    localparam int               NUM_ROWS     = 6;
    localparam int               RESET_CYCLES = 16;
    localparam int               ROW_CYCLES   = 200;
    localparam int               CYCLE_LIMIT  = RESET_CYCLES + NUM_ROWS * ROW_CYCLES;

    // kind bits are jal, branch_taken, jalr, trap
    // density is ready chance out of 16
    typedef struct packed {
        logic [7:0]       n_before;
        logic [3:0]       kind;
        fetch_pkg::xlen_t imm;
        fetch_pkg::xlen_t r1data;
        fetch_pkg::xlen_t mtvec;
        logic [7:0]       n_after;
        logic [4:0]       density;
        logic [3:0]       delay_mask;
    } row_t;

    logic                  clk = 1'b0;
    logic                  rst_i;
    fetch_pkg::redirect_t  redirect_i;
    fetch_pkg::xlen_t      mtvec_i;
    logic                  ar_valid_o;
    logic                  ar_ready_i;
    fetch_pkg::xlen_t      ar_addr_o;
    logic                  r_valid_i;
    logic                  r_ready_o;
    fetch_pkg::beat_t      r_data_i;
    logic                  out_valid_o;
    logic                  out_ready_i;
    fetch_pkg::fetch_out_t out_o;
    logic [3:0]            delay_mask;
    logic [31:0]           rnd;

    row_t             rows [NUM_ROWS];
    fetch_pkg::xlen_t exp_pc;
    fetch_pkg::xlen_t last_pc;
    fetch_pkg::xlen_t req_pc;
    logic             req_stale;
    int               pending;
    int               n_checks;
    int               n_errors;
    int               cycle_count = 0;

    always #20 clk = ~clk;

    fetch_unit #(
        .RESET_PC    (RESET_PC),
        .FETCH_DEPTH (FETCH_DEPTH)
    ) u_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .redirect_i  (redirect_i),
        .mtvec_i     (mtvec_i),
        .ar_valid_o  (ar_valid_o),
        .ar_ready_i  (ar_ready_i),
        .ar_addr_o   (ar_addr_o),
        .r_valid_i   (r_valid_i),
        .r_ready_o   (r_ready_o),
        .r_data_i    (r_data_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_o       (out_o)
    );

    fetch_mem_model u_mem (
        .clk          (clk),
        .rst_i        (rst_i),
        .rnd_i        (rnd),
        .delay_mask_i (delay_mask),
        .ar_valid_i   (ar_valid_o),
        .ar_ready_o   (ar_ready_i),
        .ar_addr_i    (ar_addr_o),
        .r_valid_o    (r_valid_i),
        .r_ready_i    (r_ready_o),
        .r_data_o     (r_data_i)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk) begin
        if (rst_i) begin
            rnd <= 32'h8a48_3704;
        end else begin
            rnd <= lcg_next(rnd);
        end
    end

    // same address tagging as the memory image
    function automatic fetch_pkg::inst_t expected_inst(input fetch_pkg::xlen_t pc);
        return {pc[31:2], 2'b11} ^ pc[63:32];
    endfunction

    // jal or branch first, then jalr, trap last
    function automatic fetch_pkg::xlen_t redirect_target(
        input fetch_pkg::redirect_t cmd,
        input fetch_pkg::xlen_t     mtvec
    );
        fetch_pkg::xlen_t sum;
        sum = cmd.r1data + cmd.imm;
        if (cmd.jal || cmd.branch_taken) begin
            return cmd.src_pc + cmd.imm;
        end
        if (cmd.jalr) begin
            return sum & ~64'd1;
        end
        return mtvec;
    endfunction

    task automatic check_pc(input fetch_pkg::xlen_t got, input fetch_pkg::xlen_t exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("mismatch out_o.pc: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_inst(input fetch_pkg::inst_t got, input fetch_pkg::inst_t exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("mismatch out_o.inst: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_addr(input fetch_pkg::xlen_t got, input fetch_pkg::xlen_t exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("mismatch ar_addr_o: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks = n_checks + 1;
        if (got !== exp) begin
            n_errors = n_errors + 1;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // ready drops on the edge that takes the last one
    task automatic accept_count(input int n, input logic [4:0] density);
        int got;
        got = 0;
        while (got < n) begin
            @(negedge clk);
            if (out_valid_o && out_ready_i) begin
                check_pc(out_o.pc, exp_pc);
                check_inst(out_o.inst, expected_inst(exp_pc));
                last_pc = exp_pc;
                exp_pc  = exp_pc + 64'd4;
                got     = got + 1;
            end
            @(posedge clk);
            if (got < n) begin
                out_ready_i <= {1'b0, rnd[31:28]} < density;
            end else begin
                out_ready_i <= 1'b0;
            end
        end
    endtask

    // the last accepted instruction acts as the control transfer
    task automatic apply_redirect(input row_t row);
        fetch_pkg::redirect_t cmd;
        cmd.jal          = row.kind[3];
        cmd.branch_taken = row.kind[2];
        cmd.jalr         = row.kind[1];
        cmd.trap         = row.kind[0];
        cmd.src_pc       = last_pc;
        cmd.imm          = row.imm;
        cmd.r1data       = row.r1data;
        redirect_i <= cmd;
        mtvec_i    <= row.mtvec;
        exp_pc = redirect_target(cmd, row.mtvec);
        @(negedge clk);
        if (out_valid_o) begin
            n_errors = n_errors + 1;
            $display("out_valid_o was high during the redirect cycle");
        end
        @(posedge clk);
        redirect_i <= '0;
    endtask

    // request side reference, following the expected fetch path
    always @(negedge clk) begin
        if (rst_i) begin
            req_pc    = RESET_PC;
            req_stale = 1'b0;
            pending   = 0;
            check_flag("ar_valid_o", ar_valid_o, 1'b0);
            check_flag("r_ready_o", r_ready_o, 1'b0);
            check_flag("out_valid_o", out_valid_o, 1'b0);
        end else begin
            check_flag("r_ready_o", r_ready_o, pending != 0);
            if (r_valid_i && r_ready_o) begin
                pending = pending - 1;
            end
            if (redirect_i.jal || redirect_i.branch_taken || redirect_i.jalr ||
                redirect_i.trap) begin
                // a held request still belongs to the old path
                if (ar_valid_o && ar_ready_i) begin
                    req_stale = 1'b0;
                end else if (ar_valid_o) begin
                    req_stale = 1'b1;
                end
                req_pc = redirect_target(redirect_i, mtvec_i);
            end else if (ar_valid_o && ar_ready_i) begin
                if (req_stale) begin
                    req_stale = 1'b0;
                end else begin
                    check_addr(ar_addr_o, {req_pc[63:3], 3'b000});
                    req_pc = req_pc + 64'd4;
                end
            end
            if (ar_valid_o && ar_ready_i) begin
                pending = pending + 1;
            end
        end
    end

    initial begin
        int errors_at_start;
        rows[0] = '{8'd8, 4'b1000, 64'h40, 64'h0, 64'h0, 8'd6, 5'd16, 4'd0};
        rows[1] = '{8'd3, 4'b0100, 64'hffff_ffff_ffff_ffe0, 64'h0, 64'h0, 8'd5, 5'd12, 4'd3};
        rows[2] = '{8'd4, 4'b0010, 64'h10, 64'h8000_2001, 64'h0, 8'd6, 5'd10, 4'd3};
        rows[3] = '{8'd2, 4'b0011, 64'h24, 64'h8000_3001, 64'h8000_0100, 8'd5, 5'd8, 4'd7};
        rows[4] = '{8'd3, 4'b0001, 64'h0, 64'h0, 64'h8000_0400, 8'd8, 5'd3, 4'd1};
        rows[5] = '{8'd4, 4'b1000, 64'h200, 64'h0, 64'h0, 8'd6, 5'd12, 4'd15};
        n_checks    = 0;
        n_errors    = 0;
        exp_pc      = RESET_PC;
        last_pc     = RESET_PC;
        rst_i       <= 1'b1;
        redirect_i  <= '0;
        mtvec_i     <= '0;
        out_ready_i <= 1'b0;
        delay_mask  <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            errors_at_start = n_errors;
            delay_mask <= rows[r].delay_mask;
            accept_count(int'(rows[r].n_before), rows[r].density);
            apply_redirect(rows[r]);
            accept_count(int'(rows[r].n_after), rows[r].density);
            if (n_errors == errors_at_start) begin
                $display("row %0d kind %b: pass", r, rows[r].kind);
            end else begin
                $display("row %0d kind %b: fail with %0d errors", r, rows[r].kind,
                         n_errors - errors_at_start);
            end
        end
        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: decode got too few instructions in %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

endmodule

// ==== hdl/fetch_ctrl_fsm.sv ====
`timescale 1ns/1ns

module fetch_ctrl_fsm #(
    parameter  int FETCH_DEPTH = 2,
    localparam int CNT_W       = $clog2(FETCH_DEPTH + 1)
) (
    input  logic             clk,
    input  logic             rst_i,
    input  fetch_pkg::xlen_t pc_i,
    input  logic             redirect_i,
    input  logic [CNT_W-1:0] inflight_cnt_i,
    input  logic [CNT_W-1:0] queue_count_i,
    input  logic             ar_ready_i,
    output logic             ar_valid_o,
    output fetch_pkg::xlen_t ar_addr_o,
    output logic             issue_o,
    output logic             issue_stale_o
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::xlen_t        hold_addr_q;
    fetch_pkg::xlen_t        issue_addr;
    logic                    stale_q;
    logic [CNT_W:0]          occupied;
    logic                    credit_ok;

    // every slot is either in flight or waiting for decode
    assign occupied  = (CNT_W + 1)'(inflight_cnt_i) + (CNT_W + 1)'(queue_count_i);
    assign credit_ok = occupied < (CNT_W + 1)'(FETCH_DEPTH);

    assign issue_addr = {pc_i[63:3], 3'b000};

    // a redirect cycle in FETCH_ISSUE would only fetch the wrong path
    always_comb begin
        case (state_q)
            fetch_pkg::FETCH_ISSUE: ar_valid_o = credit_ok & ~redirect_i;
            fetch_pkg::FETCH_HOLD:  ar_valid_o = 1'b1;
            default:                ar_valid_o = 1'b0;
        endcase
    end

    assign ar_addr_o     = (state_q == fetch_pkg::FETCH_HOLD) ? hold_addr_q : issue_addr;
    assign issue_o       = ar_valid_o & ar_ready_i;
    assign issue_stale_o = issue_o & (stale_q | redirect_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= fetch_pkg::FETCH_RESET;
            stale_q <= 1'b0;
        end else begin
            case (state_q)
                fetch_pkg::FETCH_RESET: begin
                    state_q <= fetch_pkg::FETCH_ISSUE;
                end
                fetch_pkg::FETCH_ISSUE: begin
                    if (ar_valid_o && !ar_ready_i) begin
                        state_q <= fetch_pkg::FETCH_HOLD;
                        stale_q <= 1'b0;
                    end
                end
                fetch_pkg::FETCH_HOLD: begin
                    if (ar_ready_i) begin
                        state_q <= fetch_pkg::FETCH_ISSUE;
                        stale_q <= 1'b0;
                    end else if (redirect_i) begin
                        // held request now belongs to the old path
                        stale_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= fetch_pkg::FETCH_RESET;
                end
            endcase
        end
    end

    // pc_gen may move on a redirect, so keep our own copy
    always_ff @(posedge clk) begin
        if (state_q == fetch_pkg::FETCH_ISSUE) begin
            hold_addr_q <= issue_addr;
        end
    end

    a_ar_stable: assert property (
        @(posedge clk) disable iff (rst_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o)
    );

    a_credit_limit: assert property (
        @(posedge clk) disable iff (rst_i)
        issue_o |-> occupied < (CNT_W + 1)'(FETCH_DEPTH)
    );

endmodule

// ==== hdl/fetch_inflight_counter.sv ====
`timescale 1ns/1ns

module fetch_inflight_counter #(
    parameter  int FETCH_DEPTH = 2,
    localparam int CNT_W       = $clog2(FETCH_DEPTH + 1)
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             issue_i,
    input  logic             issue_stale_i,
    input  logic             redirect_i,
    input  logic             r_valid_i,
    output logic             r_ready_o,
    output logic [CNT_W-1:0] inflight_cnt_o,
    output logic             drop_o
);

    logic [CNT_W-1:0] inflight_q;
    logic [CNT_W-1:0] stale_q;
    logic [CNT_W-1:0] inflight_left;
    logic             ret;

    // credits bound the outstanding count, so always able to sink a beat
    assign r_ready_o = inflight_q != '0;
    assign ret       = r_valid_i & r_ready_o;

    // outstanding after this cycle's return
    assign inflight_left = inflight_q - CNT_W'(ret);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            inflight_q <= '0;
            stale_q    <= '0;
        end else begin
            inflight_q <= inflight_left + CNT_W'(issue_i);
            if (redirect_i) begin
                // everything still out there is wrong path now
                stale_q <= inflight_left + CNT_W'(issue_stale_i);
            end else begin
                stale_q <= stale_q - CNT_W'(ret & drop_o) + CNT_W'(issue_stale_i);
            end
        end
    end

    // responses come back in order, so stale ones are always the oldest
    assign drop_o         = stale_q != '0;
    assign inflight_cnt_o = inflight_q;

    a_no_orphan_beat: assert property (
        @(posedge clk) disable iff (rst_i)
        r_valid_i |-> inflight_q != '0
    );

endmodule

// ==== hdl/fetch_inst_queue.sv ====
`timescale 1ns/1ns

module fetch_inst_queue #(
    parameter  int FETCH_DEPTH = 2,
    localparam int CNT_W       = $clog2(FETCH_DEPTH + 1),
    localparam int PTR_W       = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  issue_i,
    input  logic                  issue_stale_i,
    input  fetch_pkg::xlen_t      pc_i,
    input  logic                  r_valid_i,
    input  logic                  r_ready_i,
    input  fetch_pkg::beat_t      r_data_i,
    input  logic                  drop_i,
    input  logic                  redirect_i,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output fetch_pkg::fetch_out_t out_o,
    output logic [CNT_W-1:0]      count_o
);

    // slots run head -> fill (complete) -> tail (waiting on memory)
    fetch_pkg::fetch_out_t entry_q [FETCH_DEPTH];
    logic [PTR_W-1:0]      head_q;
    logic [PTR_W-1:0]      fill_q;
    logic [PTR_W-1:0]      tail_q;
    logic [CNT_W-1:0]      used_q;
    logic [CNT_W-1:0]      count_q;
    fetch_pkg::inst_t      fill_inst;
    logic                  push;
    logic                  fill;
    logic                  pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(FETCH_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // stale requests never get a slot
    assign push = issue_i & ~issue_stale_i;
    assign fill = r_valid_i & r_ready_i & ~drop_i & ~redirect_i;
    assign pop  = out_valid_o & out_ready_i;

    // word select by pc bit 2
    assign fill_inst = entry_q[fill_q].pc[2] ? r_data_i[63:32] : r_data_i[31:0];

    always_ff @(posedge clk) begin
        if (push) begin
            entry_q[tail_q].pc <= pc_i;
        end
        if (fill) begin
            entry_q[fill_q].inst <= fill_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            head_q  <= '0;
            fill_q  <= '0;
            tail_q  <= '0;
            used_q  <= '0;
            count_q <= '0;
        end else if (redirect_i) begin
            head_q  <= '0;
            fill_q  <= '0;
            tail_q  <= '0;
            used_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= next_ptr(tail_q);
            end
            if (fill) begin
                fill_q <= next_ptr(fill_q);
            end
            if (pop) begin
                head_q <= next_ptr(head_q);
            end
            used_q  <= used_q + CNT_W'(push) - CNT_W'(pop);
            count_q <= count_q + CNT_W'(fill) - CNT_W'(pop);
        end
    end

    // flushed entries must not reach decode in the redirect cycle
    assign out_valid_o = (count_q != '0) & ~redirect_i;
    assign out_o       = entry_q[head_q];
    assign count_o     = count_q;

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst_i)
        push |-> used_q < CNT_W'(FETCH_DEPTH)
    );

endmodule

// ==== hdl/fetch_pc_gen.sv ====
`timescale 1ns/1ns

module fetch_pc_gen #(
    parameter fetch_pkg::xlen_t RESET_PC = 64'h8000_0000
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 issue_i,
    input  fetch_pkg::redirect_t redirect_i,
    input  fetch_pkg::xlen_t     mtvec_i,
    output fetch_pkg::xlen_t     pc_o,
    output logic                 redirect_o
);

    fetch_pkg::xlen_t pc_q;
    fetch_pkg::xlen_t jalr_sum;
    fetch_pkg::xlen_t target;

    assign redirect_o = redirect_i.jal | redirect_i.branch_taken |
                        redirect_i.jalr | redirect_i.trap;

    assign jalr_sum = redirect_i.r1data + redirect_i.imm;

    // pc-relative first, then register-based, trap last
    always_comb begin
        if (redirect_i.jal || redirect_i.branch_taken) begin
            target = redirect_i.src_pc + redirect_i.imm;
        end else if (redirect_i.jalr) begin
            target = {jalr_sum[63:1], 1'b0};
        end else begin
            target = mtvec_i;
        end
    end

    // issue_i only pulses for requests on the current path
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_o) begin
            pc_q <= target;
        end else if (issue_i) begin
            pc_q <= pc_q + 64'd4;
        end
    end

    assign pc_o = pc_q;

    // no compressed instructions, so every fetch pc is word aligned
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst_i)
        pc_o[1:0] == 2'b00
    );

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // architectural register width
    typedef logic [63:0] xlen_t;

    // uncompressed instruction word
    typedef logic [31:0] inst_t;

    // one read-data beat, two instruction words
    typedef logic [63:0] beat_t;

    // control transfer from execute, one cycle wide
    typedef struct packed {
        logic  jal;
        logic  branch_taken;
        logic  jalr;
        logic  trap;
        xlen_t src_pc;
        xlen_t imm;
        xlen_t r1data;
    } redirect_t;

    // entry handed to decode
    typedef struct packed {
        xlen_t pc;
        inst_t inst;
    } fetch_out_t;

    // read-address channel control
    typedef enum logic [1:0] {
        FETCH_RESET,
        FETCH_ISSUE,
        FETCH_HOLD
    } fetch_state_e;

endpackage

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit #(
    parameter fetch_pkg::xlen_t RESET_PC    = 64'h8000_0000,
    parameter int               FETCH_DEPTH = 2
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  fetch_pkg::redirect_t  redirect_i,
    input  fetch_pkg::xlen_t      mtvec_i,
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    output fetch_pkg::xlen_t      ar_addr_o,
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    input  fetch_pkg::beat_t      r_data_i,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output fetch_pkg::fetch_out_t out_o
);

    localparam int CNT_W = $clog2(FETCH_DEPTH + 1);

    fetch_pkg::xlen_t pc;
    logic             redirect;
    logic             issue;
    logic             issue_stale;
    logic             pc_advance;
    logic             drop;
    logic [CNT_W-1:0] inflight_cnt;
    logic [CNT_W-1:0] queue_count;

    // a stale handshake leaves the redirect target in place
    assign pc_advance = issue & ~issue_stale;

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk        (clk),
        .rst_i      (rst_i),
        .issue_i    (pc_advance),
        .redirect_i (redirect_i),
        .mtvec_i    (mtvec_i),
        .pc_o       (pc),
        .redirect_o (redirect)
    );

    fetch_ctrl_fsm #(
        .FETCH_DEPTH (FETCH_DEPTH)
    ) u_ctrl_fsm (
        .clk            (clk),
        .rst_i          (rst_i),
        .pc_i           (pc),
        .redirect_i     (redirect),
        .inflight_cnt_i (inflight_cnt),
        .queue_count_i  (queue_count),
        .ar_ready_i     (ar_ready_i),
        .ar_valid_o     (ar_valid_o),
        .ar_addr_o      (ar_addr_o),
        .issue_o        (issue),
        .issue_stale_o  (issue_stale)
    );

    fetch_inflight_counter #(
        .FETCH_DEPTH (FETCH_DEPTH)
    ) u_inflight_counter (
        .clk            (clk),
        .rst_i          (rst_i),
        .issue_i        (issue),
        .issue_stale_i  (issue_stale),
        .redirect_i     (redirect),
        .r_valid_i      (r_valid_i),
        .r_ready_o      (r_ready_o),
        .inflight_cnt_o (inflight_cnt),
        .drop_o         (drop)
    );

    fetch_inst_queue #(
        .FETCH_DEPTH (FETCH_DEPTH)
    ) u_inst_queue (
        .clk           (clk),
        .rst_i         (rst_i),
        .issue_i       (issue),
        .issue_stale_i (issue_stale),
        .pc_i          (pc),
        .r_valid_i     (r_valid_i),
        .r_ready_i     (r_ready_o),
        .r_data_i      (r_data_i),
        .drop_i        (drop),
        .redirect_i    (redirect),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_o         (out_o),
        .count_o       (queue_count)
    );

endmodule

// ==== verilog.f ====
hdl/fetch_pkg.sv
hdl/fetch_pc_gen.sv
hdl/fetch_ctrl_fsm.sv
hdl/fetch_inflight_counter.sv
hdl/fetch_inst_queue.sv
hdl/fetch_unit.sv
dv/fetch_mem_model.sv
dv/fetch_unit_tb.sv
